//--- gfx_striped.f
source/gfx_striped_pkg.sv
source/gfx_apb_regs.sv
source/gfx_pattern_writer.sv
source/gfx_stripe_fb.sv
source/gfx_vga_timing.sv
source/gfx_scanout.sv
source/gfx_striped_top.sv
tb/gfx_striped_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal -f gfx_striped.f \
  --top-module gfx_striped_tb -o gfx_striped_sim > build.log 2>&1 &&
./obj_dir/gfx_striped_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

//--- source/gfx_apb_regs.sv
// apb slave for the demo, holds control, fill command, status, error and frame counters
`timescale 1ns/1ns

module gfx_apb_regs
  import gfx_striped_pkg::*;
(
  input  logic                      pixel_clk,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic                      fill_busy,
  input  logic                      pix_error,
  input  logic                      frame_tick,
  output logic                      video_en,
  output logic [SEED_WIDTH-1:0]     seed,
  output logic                      fill_start
);

  logic                 access;
  logic                 wr_access;
  logic                 addr_hit;
  logic [CNT_WIDTH-1:0] err_cnt;
  logic [CNT_WIDTH-1:0] frame_cnt;

  // no wait states, every transfer ends in its access phase
  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign pready    = 1'b1;
  assign pslverr   = access && !addr_hit;

  always_comb begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      REG_CTRL: begin
        prdata[0]   = video_en;
        prdata[7:4] = seed;
      end
      REG_CMD:       prdata = '0;
      REG_STATUS:    prdata[0] = fill_busy;
      REG_ERR_CNT:   prdata[CNT_WIDTH-1:0] = err_cnt;
      REG_FRAME_CNT: prdata[CNT_WIDTH-1:0] = frame_cnt;
      default:       addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      video_en   <= 1'b0;
      seed       <= '0;
      fill_start <= 1'b0;
      err_cnt    <= '0;
      frame_cnt  <= '0;
    end else begin
      fill_start <= wr_access && (paddr == REG_CMD) && pwdata[0];
      if (wr_access && (paddr == REG_CTRL)) begin
        video_en <= pwdata[0];
        seed     <= pwdata[7:4];
      end
      // clear wins over a same-cycle increment
      if (wr_access && (paddr == REG_ERR_CNT)) begin
        err_cnt <= '0;
      end else if (pix_error && (err_cnt != '1)) begin
        err_cnt <= err_cnt + 1'b1;
      end
      if (frame_tick) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

endmodule

//--- source/gfx_pattern_writer.sv
// fills the framebuffer with the test pattern, one pixel per cycle after each fill command
`timescale 1ns/1ns

module gfx_pattern_writer
  import gfx_striped_pkg::*;
(
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  input  logic                   fill_start,
  input  logic [SEED_WIDTH-1:0]  seed,
  output logic                   fill_busy,
  output logic                   wr_en,
  output logic [X_WIDTH-1:0]     wr_x,
  output logic [Y_WIDTH-1:0]     wr_y,
  output logic [PIXEL_WIDTH-1:0] wr_data
);

  logic [SEED_WIDTH-1:0] seed_q;
  logic                  last_x;
  logic                  last_y;

  assign last_x = (wr_x == X_WIDTH'(H_ACTIVE - 1));
  assign last_y = (wr_y == Y_WIDTH'(V_ACTIVE - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      fill_busy <= 1'b0;
      wr_x      <= '0;
      wr_y      <= '0;
      seed_q    <= '0;
    end else if (!fill_busy) begin
      // a start while busy falls through to the raster branch
      if (fill_start) begin
        fill_busy <= 1'b1;
        wr_x      <= '0;
        wr_y      <= '0;
        seed_q    <= seed;
      end
    end else if (last_x) begin
      wr_x <= '0;
      if (last_y) begin
        fill_busy <= 1'b0;
        wr_y      <= '0;
      end else begin
        wr_y <= wr_y + 1'b1;
      end
    end else begin
      wr_x <= wr_x + 1'b1;
    end
  end

  // one write for every busy cycle
  assign wr_en   = fill_busy;
  assign wr_data = pattern_pixel(wr_x, wr_y, seed_q);

endmodule

//--- source/gfx_scanout.sv
// two-stage scan-out from the framebuffer to the vga outputs, with blanking and pattern check
`timescale 1ns/1ns

module gfx_scanout
  import gfx_striped_pkg::*;
(
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  input  logic [X_WIDTH-1:0]     h_count,
  input  logic [Y_WIDTH-1:0]     v_count,
  input  logic                   active,
  input  logic                   hsync_raw,
  input  logic                   vsync_raw,
  input  logic                   video_en,
  input  logic [SEED_WIDTH-1:0]  seed,
  input  logic                   fill_busy,
  input  logic [PIXEL_WIDTH-1:0] rd_data,
  output logic [X_WIDTH-1:0]     rd_x,
  output logic [Y_WIDTH-1:0]     rd_y,
  output logic [COLOR_WIDTH-1:0] vga_red,
  output logic [COLOR_WIDTH-1:0] vga_grn,
  output logic [COLOR_WIDTH-1:0] vga_blu,
  output logic                   vga_hsync,
  output logic                   vga_vsync,
  output logic                   vga_de,
  output logic                   vga_error,
  output logic                   pix_error
);

  logic [X_WIDTH-1:0] x_q;
  logic [Y_WIDTH-1:0] y_q;
  logic               active_q;
  logic               hsync_q;
  logic               vsync_q;
  logic               show;
  logic               bad_pixel;

  // request goes out straight from the counters
  assign rd_x = h_count;
  assign rd_y = v_count;

  // stage 1 lines up with the returning read word
  always_ff @(posedge pixel_clk) begin
    x_q <= h_count;
    y_q <= v_count;
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      hsync_q  <= 1'b1;
      vsync_q  <= 1'b1;
    end else begin
      active_q <= active;
      hsync_q  <= hsync_raw;
      vsync_q  <= vsync_raw;
    end
  end

  assign show      = active_q && video_en && !fill_busy;
  assign bad_pixel = show && (rd_data != pattern_pixel(x_q, y_q, seed));

  // stage 2 drives the pins
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_de    <= 1'b0;
      vga_error <= 1'b0;
    end else begin
      vga_red   <= show ? rd_data[COLOR_WIDTH-1:0] : '0;
      vga_grn   <= show ? rd_data[2*COLOR_WIDTH-1:COLOR_WIDTH] : '0;
      vga_blu   <= show ? rd_data[3*COLOR_WIDTH-1:2*COLOR_WIDTH] : '0;
      vga_hsync <= hsync_q;
      vga_vsync <= vsync_q;
      vga_de    <= active_q;
      vga_error <= bad_pixel;
    end
  end

  assign pix_error = vga_error;

endmodule

//--- source/gfx_stripe_fb.sv
// framebuffer striped across dual-port banks, written by the pattern writer and read by scan-out
`timescale 1ns/1ns

module gfx_stripe_fb
  import gfx_striped_pkg::*;
(
  input  logic                   pixel_clk,
  input  logic                   wr_en,
  input  logic [X_WIDTH-1:0]     wr_x,
  input  logic [Y_WIDTH-1:0]     wr_y,
  input  logic [PIXEL_WIDTH-1:0] wr_data,
  input  logic [X_WIDTH-1:0]     rd_x,
  input  logic [Y_WIDTH-1:0]     rd_y,
  output logic [PIXEL_WIDTH-1:0] rd_data
);

  logic [SEL_WIDTH-1:0]       wr_bank;
  logic [BANK_ADDR_WIDTH-1:0] wr_addr;
  logic [SEL_WIDTH-1:0]       rd_bank;
  logic [BANK_ADDR_WIDTH-1:0] rd_addr;
  logic [SEL_WIDTH-1:0]       rd_bank_q;
  logic [PIXEL_WIDTH-1:0]     bank_q [NUM_S];

  // low x bits pick the bank, row and upper x bits pick the word
  assign wr_bank = wr_x[SEL_WIDTH-1:0];
  assign wr_addr = {wr_y[Y_ACT_WIDTH-1:0], wr_x[X_ACT_WIDTH-1:SEL_WIDTH]};
  assign rd_bank = rd_x[SEL_WIDTH-1:0];
  assign rd_addr = {rd_y[Y_ACT_WIDTH-1:0], rd_x[X_ACT_WIDTH-1:SEL_WIDTH]};

  for (genvar s = 0; s < NUM_S; s++) begin : g_bank
    logic [PIXEL_WIDTH-1:0] mem [BANK_DEPTH];

    always_ff @(posedge pixel_clk) begin
      if (wr_en && (wr_bank == SEL_WIDTH'(s))) begin
        mem[wr_addr] <= wr_data;
      end
    end

    // every bank reads the same word, the select below picks one
    always_ff @(posedge pixel_clk) begin
      bank_q[s] <= mem[rd_addr];
    end
  end

  always_ff @(posedge pixel_clk) begin
    rd_bank_q <= rd_bank;
  end

  // word returns one cycle after the request
  assign rd_data = bank_q[rd_bank_q];

endmodule

//--- source/gfx_striped_pkg.sv
// shared video mode, bank geometry, register map and test pattern, imported by every RTL module
package gfx_striped_pkg;

  // pixel format, red low, green middle, blue high
  localparam int COLOR_WIDTH = 4;
  localparam int PIXEL_WIDTH = 3 * COLOR_WIDTH;
  localparam int SEED_WIDTH  = 4;

  // tiny 16x8 video mode, both syncs active low
  localparam int H_ACTIVE     = 16;
  localparam int H_FP         = 2;
  localparam int H_SYNC       = 3;
  localparam int H_BP         = 3;
  localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

  localparam int V_ACTIVE     = 8;
  localparam int V_FP         = 1;
  localparam int V_SYNC       = 2;
  localparam int V_BP         = 1;
  localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  localparam int X_WIDTH     = 5;
  localparam int Y_WIDTH     = 4;
  localparam int X_ACT_WIDTH = $clog2(H_ACTIVE);
  localparam int Y_ACT_WIDTH = $clog2(V_ACTIVE);

  // pixel x goes to bank x mod NUM_S
  localparam int NUM_S           = 4;
  localparam int SEL_WIDTH       = $clog2(NUM_S);
  localparam int BANK_DEPTH      = H_ACTIVE * V_ACTIVE / NUM_S;
  localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);

  // apb register map
  localparam int APB_ADDR_WIDTH = 5;
  localparam int APB_DATA_WIDTH = 32;
  localparam int CNT_WIDTH      = 16;

  localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL      = 5'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CMD       = 5'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS    = 5'h08;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_ERR_CNT   = 5'h0C;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_FRAME_CNT = 5'h10;

  // reference pattern, shared by the writer and the checker
  function automatic logic [PIXEL_WIDTH-1:0] pattern_pixel(
    input logic [X_WIDTH-1:0]    x,
    input logic [Y_WIDTH-1:0]    y,
    input logic [SEED_WIDTH-1:0] seed
  );
    logic [COLOR_WIDTH-1:0] red;
    logic [COLOR_WIDTH-1:0] grn;
    logic [COLOR_WIDTH-1:0] blu;
    red = x[COLOR_WIDTH-1:0] + COLOR_WIDTH'(seed);
    grn = COLOR_WIDTH'(y) + COLOR_WIDTH'(seed);
    blu = x[COLOR_WIDTH-1:0] ^ COLOR_WIDTH'(y);
    return {blu, grn, red};
  endfunction

endpackage

//--- source/gfx_striped_top.sv
// top of the striped framebuffer demo, apb control in and vga stream out
`timescale 1ns/1ns

module gfx_striped_top
  import gfx_striped_pkg::*;
(
  input  logic                      pixel_clk,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic [COLOR_WIDTH-1:0]    vga_red,
  output logic [COLOR_WIDTH-1:0]    vga_grn,
  output logic [COLOR_WIDTH-1:0]    vga_blu,
  output logic                      vga_hsync,
  output logic                      vga_vsync,
  output logic                      vga_de,
  output logic                      vga_error
);

  logic                   video_en;
  logic [SEED_WIDTH-1:0]  seed;
  logic                   fill_start;
  logic                   fill_busy;
  logic                   pix_error;
  logic                   frame_tick;
  logic                   wr_en;
  logic [X_WIDTH-1:0]     wr_x;
  logic [Y_WIDTH-1:0]     wr_y;
  logic [PIXEL_WIDTH-1:0] wr_data;
  logic [X_WIDTH-1:0]     rd_x;
  logic [Y_WIDTH-1:0]     rd_y;
  logic [PIXEL_WIDTH-1:0] rd_data;
  logic [X_WIDTH-1:0]     h_count;
  logic [Y_WIDTH-1:0]     v_count;
  logic                   active;
  logic                   hsync_raw;
  logic                   vsync_raw;

  gfx_apb_regs u_gfx_apb_regs (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .fill_busy  (fill_busy),
    .pix_error  (pix_error),
    .frame_tick (frame_tick),
    .video_en   (video_en),
    .seed       (seed),
    .fill_start (fill_start)
  );

  gfx_pattern_writer u_gfx_pattern_writer (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .fill_start (fill_start),
    .seed       (seed),
    .fill_busy  (fill_busy),
    .wr_en      (wr_en),
    .wr_x       (wr_x),
    .wr_y       (wr_y),
    .wr_data    (wr_data)
  );

  gfx_stripe_fb u_gfx_stripe_fb (
    .pixel_clk (pixel_clk),
    .wr_en     (wr_en),
    .wr_x      (wr_x),
    .wr_y      (wr_y),
    .wr_data   (wr_data),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .rd_data   (rd_data)
  );

  gfx_vga_timing u_gfx_vga_timing (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .h_count    (h_count),
    .v_count    (v_count),
    .active     (active),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .frame_tick (frame_tick)
  );

  gfx_scanout u_gfx_scanout (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .h_count   (h_count),
    .v_count   (v_count),
    .active    (active),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw),
    .video_en  (video_en),
    .seed      (seed),
    .fill_busy (fill_busy),
    .rd_data   (rd_data),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de),
    .vga_error (vga_error),
    .pix_error (pix_error)
  );

endmodule

//--- source/gfx_vga_timing.sv
// free-running raster counters with sync, active-area and frame tick decode for the video mode
`timescale 1ns/1ns

module gfx_vga_timing
  import gfx_striped_pkg::*;
(
  input  logic               pixel_clk,
  input  logic               rst_n,
  output logic [X_WIDTH-1:0] h_count,
  output logic [Y_WIDTH-1:0] v_count,
  output logic               active,
  output logic               hsync_raw,
  output logic               vsync_raw,
  output logic               frame_tick
);

  logic line_end;
  logic frame_end;

  assign line_end  = (h_count == X_WIDTH'(H_TOTAL - 1));
  assign frame_end = (v_count == Y_WIDTH'(V_TOTAL - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      if (frame_end) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign active = (h_count < X_WIDTH'(H_ACTIVE)) && (v_count < Y_WIDTH'(V_ACTIVE));

  // active low sync windows
  assign hsync_raw = !((h_count >= X_WIDTH'(H_SYNC_START)) &&
                       (h_count <  X_WIDTH'(H_SYNC_END)));
  assign vsync_raw = !((v_count >= Y_WIDTH'(V_SYNC_START)) &&
                       (v_count <  Y_WIDTH'(V_SYNC_END)));

  // first cycle of the vsync window
  assign frame_tick = (h_count == '0) && (v_count == Y_WIDTH'(V_SYNC_START));

endmodule

//--- tb/gfx_striped_tb.sv
// testbench for the striped framebuffer demo, drives apb and checks the vga stream with assertions
`timescale 1ns/1ns

module gfx_striped_tb
  import gfx_striped_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int TEST_FRAMES  = 25;
  localparam int WATCHDOG_NS  = TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD;

  logic                      pixel_clk;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic [COLOR_WIDTH-1:0]    vga_red;
  logic [COLOR_WIDTH-1:0]    vga_grn;
  logic [COLOR_WIDTH-1:0]    vga_blu;
  logic                      vga_hsync;
  logic                      vga_vsync;
  logic                      vga_de;
  logic                      vga_error;

  // expectations driven by the stimulus
  logic                      chk_rd;
  logic                      chk_slv;
  logic [APB_DATA_WIDTH-1:0] exp_rdata;
  logic                      exp_slverr;
  logic                      expect_blank;
  logic                      expect_err;
  logic                      check_pix;
  int                        cur_seed;
  logic [SEED_WIDTH-1:0]     pix_seed;
  logic [SEED_WIDTH-1:0]     bad_seed;
  integer                    seed_var;
  int                        errors = 0;

  // frame tracker state
  logic de_last;
  logic hs_last;
  logic vs_last;
  logic synced;
  int   de_run;
  int   hs_run;
  int   vs_run;
  int   line_idx;
  int   frames_seen;
  int   err_pulses;

  gfx_striped_top u_gfx_striped_top (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de),
    .vga_error (vga_error)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
  end

  // expected pixel word, red low and blue high
  function automatic logic [PIXEL_WIDTH-1:0] ref_color(input int x, input int y, input int s);
    logic [COLOR_WIDTH-1:0] r;
    logic [COLOR_WIDTH-1:0] g;
    logic [COLOR_WIDTH-1:0] b;
    r = COLOR_WIDTH'((x + s) % 16);
    g = COLOR_WIDTH'((y + s) % 16);
    b = COLOR_WIDTH'((x ^ y) % 16);
    return {b, g, r};
  endfunction

  task automatic write_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                           input logic [APB_DATA_WIDTH-1:0] data, input logic slverr);
    @(posedge pixel_clk);
    #1;
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge pixel_clk);
    #1;
    penable    = 1'b1;
    exp_slverr = slverr;
    chk_slv    = 1'b1;
    @(posedge pixel_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    chk_slv = 1'b0;
  endtask

  task automatic read_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                          input logic [APB_DATA_WIDTH-1:0] data, input logic slverr);
    @(posedge pixel_clk);
    #1;
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge pixel_clk);
    #1;
    penable    = 1'b1;
    exp_rdata  = data;
    exp_slverr = slverr;
    chk_rd     = 1'b1;
    chk_slv    = 1'b1;
    @(posedge pixel_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    chk_rd  = 1'b0;
    chk_slv = 1'b0;
  endtask

  // returns just after the tracker has counted the new frame
  task automatic wait_vsync();
    @(negedge vga_vsync);
    @(posedge pixel_clk);
    #1;
  endtask

  // fill of 128 cycles, colours blanked while it runs
  task automatic run_fill();
    write_reg(REG_CMD, 32'h1, 1'b0);
    repeat (2) @(posedge pixel_clk);
    #1;
    expect_blank = 1'b1;
    read_reg(REG_STATUS, 32'h1, 1'b0);
    repeat (110) @(posedge pixel_clk);
    #1;
    expect_blank = 1'b0;
    repeat (20) @(posedge pixel_clk);
    read_reg(REG_STATUS, 32'h0, 1'b0);
  endtask

  // rebuilds x and y from data enable and the vsync falling edge
  always @(posedge pixel_clk) begin
    if (!rst_n) begin
      de_last     <= 1'b0;
      hs_last     <= 1'b1;
      vs_last     <= 1'b1;
      synced      <= 1'b0;
      de_run      <= 0;
      hs_run      <= 0;
      vs_run      <= 0;
      line_idx    <= 0;
      frames_seen <= 0;
      err_pulses  <= 0;
    end else begin
      de_last <= vga_de;
      hs_last <= vga_hsync;
      vs_last <= vga_vsync;
      de_run  <= vga_de ? de_run + 1 : 0;
      hs_run  <= vga_hsync ? 0 : hs_run + 1;
      vs_run  <= vga_vsync ? 0 : vs_run + 1;
      if (vs_last && !vga_vsync) begin
        line_idx    <= 0;
        synced      <= 1'b1;
        frames_seen <= frames_seen + 1;
      end else if (de_last && !vga_de) begin
        line_idx <= line_idx + 1;
      end
      if (vga_error) begin
        err_pulses <= err_pulses + 1;
      end
    end
  end

  a_prdata: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (psel && penable && chk_rd) |-> (prdata == exp_rdata))
    else begin
      errors++;
      $display("Mismatch prdata at %h: got %h expected %h", paddr, prdata, exp_rdata);
    end

  a_pslverr: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (psel && penable && chk_slv) |-> (pslverr == exp_slverr))
    else begin
      errors++;
      $display("Mismatch pslverr at %h: got %h expected %h", paddr, pslverr, exp_slverr);
    end

  a_pready: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (psel && penable) |-> pready)
    else begin
      errors++;
      $display("APB transfer saw pready low in its access phase");
    end

  a_line_len: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (de_last && !vga_de) |-> (de_run == H_ACTIVE))
    else begin
      errors++;
      $display("Mismatch vga_de run: got %h expected %h", de_run, H_ACTIVE);
    end

  a_hsync_len: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (!hs_last && vga_hsync) |-> (hs_run == H_SYNC))
    else begin
      errors++;
      $display("Mismatch vga_hsync width: got %h expected %h", hs_run, H_SYNC);
    end

  a_vsync_len: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (!vs_last && vga_vsync) |-> (vs_run == V_SYNC * H_TOTAL))
    else begin
      errors++;
      $display("Mismatch vga_vsync width: got %h expected %h", vs_run, V_SYNC * H_TOTAL);
    end

  a_frame_lines: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (synced && vs_last && !vga_vsync) |-> (line_idx == V_ACTIVE))
    else begin
      errors++;
      $display("Mismatch active lines: got %h expected %h", line_idx, V_ACTIVE);
    end

  // colours must be dark outside the active area and while blanked
  a_blank: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (expect_blank || !vga_de) |-> ({vga_blu, vga_grn, vga_red} == '0))
    else begin
      errors++;
      $display("Mismatch vga_blu vga_grn vga_red while blanked: got %h expected 000",
               {vga_blu, vga_grn, vga_red});
    end

  a_error: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    vga_error == (expect_err && vga_de))
    else begin
      errors++;
      $display("Mismatch vga_error at x %0d y %0d: got %h expected %h",
               de_run, line_idx, vga_error, expect_err && vga_de);
    end

  a_pixel: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (check_pix && vga_de) |-> ({vga_blu, vga_grn, vga_red} ==
                                ref_color(de_run, line_idx, cur_seed)))
    else begin
      errors++;
      $display("Mismatch vga_blu vga_grn vga_red at x %0d y %0d: got %h expected %h",
               de_run, line_idx, {vga_blu, vga_grn, vga_red},
               ref_color(de_run, line_idx, cur_seed));
    end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d frames", TEST_FRAMES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    chk_rd       = 1'b0;
    chk_slv      = 1'b0;
    exp_rdata    = '0;
    exp_slverr   = 1'b0;
    expect_blank = 1'b1;
    expect_err   = 1'b0;
    check_pix    = 1'b0;
    cur_seed     = 0;
    seed_var     = 32'h5d10;
    repeat (10) @(posedge pixel_clk);
    #1;
    rst_n = 1'b1;

    // register access, video still off
    write_reg(REG_CTRL, 32'hA0, 1'b0);
    read_reg(REG_CTRL, 32'hA0, 1'b0);
    // bit 0 clear, so no fill starts
    write_reg(REG_CMD, 32'hFFFF_FFFE, 1'b0);
    read_reg(REG_CMD, 32'h0, 1'b0);
    write_reg(5'h14, 32'hFF, 1'b1);
    read_reg(5'h1C, 32'h0, 1'b1);
    read_reg(REG_CTRL, 32'hA0, 1'b0);
    read_reg(REG_STATUS, 32'h0, 1'b0);
    read_reg(REG_ERR_CNT, 32'h0, 1'b0);
    repeat (2) wait_vsync();
    read_reg(REG_FRAME_CNT, frames_seen, 1'b0);

    // fill with a random seed and video off, started in vertical blank
    pix_seed = SEED_WIDTH'($random(seed_var));
    wait_vsync();
    write_reg(REG_CTRL, {24'h0, pix_seed, 4'h0}, 1'b0);
    run_fill();

    // filled frame stays dark while video is off
    expect_blank = 1'b1;
    wait_vsync();
    expect_blank = 1'b0;
    write_reg(REG_CTRL, {24'h0, pix_seed, 4'h1}, 1'b0);
    cur_seed  = int'(pix_seed);
    check_pix = 1'b1;
    repeat (3) wait_vsync();
    read_reg(REG_ERR_CNT, 32'h0, 1'b0);
    read_reg(REG_FRAME_CNT, frames_seen, 1'b0);

    // new seed without a refill, every shown pixel is wrong
    check_pix = 1'b0;
    bad_seed  = pix_seed + SEED_WIDTH'(1 + ($random(seed_var) & 7));
    write_reg(REG_CTRL, {24'h0, bad_seed, 4'h1}, 1'b0);
    expect_err = 1'b1;
    repeat (2) wait_vsync();
    expect_err = 1'b0;
    read_reg(REG_ERR_CNT, err_pulses, 1'b0);
    write_reg(REG_ERR_CNT, 32'h0, 1'b0);
    read_reg(REG_ERR_CNT, 32'h0, 1'b0);

    // refill with the new seed
    run_fill();
    cur_seed  = int'(bad_seed);
    check_pix = 1'b1;
    repeat (2) wait_vsync();
    read_reg(REG_ERR_CNT, 32'h0, 1'b0);
    read_reg(REG_FRAME_CNT, frames_seen, 1'b0);

    $display("summary: %0d errors, %0d frames, %0d error pulses", errors, frames_seen,
             err_pulses);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
